// ==== all.f ====
src/busPkg.sv
src/cpuPkg.sv
src/wordStore.sv
src/alu.sv
src/progCounter.sv
src/cpuControl.sv
src/apbSlave.sv
src/miniCpu.sv
dv/clkGen.sv
dv/cpu_props.sv
dv/tb_miniCpu.sv

// ==== dv/clkGen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock
module clkGen #(
	parameter realtime PERIOD_NS = 8.0
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
	end

	always #(PERIOD_NS / 2.0) o_clk = ~o_clk; // Half period per toggle

endmodule

`default_nettype wire

// ==== dv/cpu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

// Checker shared by the controller and bus instances, unused inputs tied off
module cpuProps (
	input wire i_clk,
	input wire i_reset,
	input wire i_traceValid,
	input wire i_inExec,
	input wire i_busy,
	input wire i_halted,
	input wire i_access,
	input wire i_pready
);

	// Writeback only happens in EXEC
	traceInExec: assert property (@(posedge i_clk) disable iff (i_reset)
		i_traceValid |-> i_inExec)
		else $error("trace valid outside EXEC");

	// Running and finished are exclusive
	busyNotHalted: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_busy && i_halted))
		else $error("busy and halted both high");

	// Zero wait states
	readyInAccess: assert property (@(posedge i_clk) disable iff (i_reset)
		i_access |-> i_pready)
		else $error("pready low in an access phase");

endmodule

bind cpuControl cpuProps uCtrlProps (
	.i_clk(i_clk), .i_reset(i_reset), .i_traceValid(o_trace.valid),
	.i_inExec(state == cpuPkg::ST_EXEC), .i_busy(o_status.busy),
	.i_halted(o_status.halted), .i_access(1'b0), .i_pready(1'b1)
);

bind apbSlave cpuProps uBusProps (
	.i_clk(i_clk), .i_reset(i_reset), .i_traceValid(1'b0), .i_inExec(1'b1),
	.i_busy(i_status.busy), .i_halted(i_status.halted),
	.i_access(accessPh), .i_pready(o_apb.pready)
);

`default_nettype wire

// ==== dv/cpu_stim.txt ====
// Program length, program words, then run count
// Per run: entry count, entries {rd, value, n/z/p/c}, status {retired, halted, busy}
0000000E
00788024 00551068 00019400 000A2200 000A9200 00232600 002B4200 0033A600
00180800 00820016 007A81FE 0081001A 00428002 00C00000
00000002
// Run 1 from reset
0000000A
00100123 00212342 00312462 004EDDE8 00500007
00612042 006EDDE8 00700722 000EDDE9 005EDDF8
00000C02
// Run 2, r0 preserved changes the first carry
0000000A
00100122 00212342 00312462 004EDDE8 00500007
00612042 006EDDE8 00700722 000EDDE9 005EDDF8
00000C02

// ==== dv/tb_miniCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_miniCpu;

	logic              clk;
	logic              reset;
	busPkg::apbReq_t   apbReq;
	busPkg::apbRsp_t   apbRsp;
	cpuPkg::wbTrace_t  trace;

	logic [31:0]       stim [0:127];    // Flat stim image
	cpuPkg::wbTrace_t  traceQ [$];      // Collected writebacks
	int                errCount;
	int                progLen;
	int                numRuns;
	realtime           wdLimit;
	logic              wdArmed;

	clkGen #(.PERIOD_NS(8.0)) uClk (.o_clk(clk));

	miniCpu uut (
		.i_clk(clk), .i_reset(reset), .i_apb(apbReq), .o_apb(apbRsp), .o_trace(trace)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic failRun(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input cpuPkg::dataWord_t got,
	                         input cpuPkg::dataWord_t exp);
		if (got !== exp) begin
			errCount++;
			failRun($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkCcodes(input string name, input cpuPkg::ccodes_t got,
	                           input cpuPkg::ccodes_t exp);
		if (got !== exp) begin
			errCount++;
			failRun($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkStatus(input string name, input cpuPkg::status_t got,
	                           input cpuPkg::status_t exp);
		if (got !== exp) begin
			errCount++;
			failRun($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkApb(input string name, input busPkg::apbRsp_t got,
	                        input busPkg::apbRsp_t exp);
		if (got !== exp) begin
			errCount++;
			failRun($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB host
	////////////////////////////////////////////////////////////////////////////

	// Entered and left on a falling edge
	task automatic apbTransfer(input logic write, input logic [11:0] addr,
	                           input logic [31:0] wdata, output busPkg::apbRsp_t rsp);
		int gap;
		gap = $urandom_range(3, 0);
		repeat (gap) @(negedge clk);
		apbReq.psel    = 1'b1; // Setup
		apbReq.penable = 1'b0;
		apbReq.pwrite  = write;
		apbReq.paddr   = addr;
		apbReq.pwdata  = wdata;
		@(negedge clk);
		apbReq.penable = 1'b1; // Access
		#1;
		rsp = apbRsp;          // Mid-cycle, settled
		@(negedge clk);
		apbReq = '0;
	endtask

	task automatic apbWrite(input logic [11:0] addr, input logic [31:0] wdata,
	                        input logic expErr);
		busPkg::apbRsp_t rsp;
		busPkg::apbRsp_t exp;
		apbTransfer(1'b1, addr, wdata, rsp);
		exp = '{prdata: 32'h0, pready: 1'b1, pslverr: expErr};
		checkApb($sformatf("apb write 0x%h", addr), rsp, exp);
	endtask

	task automatic apbReadCheck(input logic [11:0] addr, input logic [31:0] expData,
	                            input logic expErr);
		busPkg::apbRsp_t rsp;
		busPkg::apbRsp_t exp;
		apbTransfer(1'b0, addr, 32'h0, rsp);
		exp = '{prdata: expData, pready: 1'b1, pslverr: expErr};
		checkApb($sformatf("apb read 0x%h", addr), rsp, exp);
	endtask

	task automatic readStatus(output cpuPkg::status_t st);
		busPkg::apbRsp_t rsp;
		apbTransfer(1'b0, busPkg::ADDR_STATUS, 32'h0, rsp);
		if (rsp.pslverr)
			failRun("status read returned an error response");
		st.busy    = rsp.prdata[0];
		st.halted  = rsp.prdata[1];
		st.retired = rsp.prdata[15:8];
	endtask

	// Poll until HALT is reached
	task automatic waitHalted(output cpuPkg::status_t st);
		int polls;
		polls = 0;
		readStatus(st);
		while (!st.halted) begin
			polls++;
			if (polls > 200)
				failRun("program did not reach HALT within the poll limit");
			readStatus(st);
		end
	endtask

	task automatic checkProgram();
		for (int i = 0; i < progLen; i++)
			apbReadCheck(busPkg::IMEM_BASE + 12'(i * 4), stim[1 + i], 1'b0);
	endtask

	// Trace monitor, stable at mid-cycle
	always @(negedge clk) begin
		if (!reset && trace.valid)
			traceQ.push_back(trace);
	end

	// Watchdog
	initial begin
		wait (wdArmed === 1'b1);
		#(wdLimit);
		failRun("watchdog timeout, the run did not finish in time");
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int               seedInit;
		int               ptr;
		int               numEntries;
		int               apbEst;
		logic [31:0]      entry;
		cpuPkg::status_t  st;
		cpuPkg::status_t  expSt;
		seedInit = $urandom(97071);
		apbReq   = '0;
		reset    = 1'b1;
		errCount = 0;
		wdArmed  = 1'b0;
		$readmemh("dv/cpu_stim.txt", stim);
		progLen = int'(stim[0]);
		numRuns = int'(stim[progLen + 1]);

		// Instruction cycles plus bus traffic, times a margin of 4
		apbEst  = (2 * progLen + 10 + numRuns * (progLen + 4)) * 6;
		wdLimit = (progLen * 2 * numRuns + apbEst) * 8.0 * 4;
		wdArmed = 1'b1;

		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Reset values
		if (trace.valid !== 1'b0)
			failRun("trace valid is high after reset");
		if (apbRsp.pslverr !== 1'b0)
			failRun("pslverr is high after reset");
		readStatus(st);
		checkStatus("status after reset", st, '0);

		// Load and read back
		for (int i = 0; i < progLen; i++)
			apbWrite(busPkg::IMEM_BASE + 12'(i * 4), stim[1 + i], 1'b0);
		checkProgram();

		ptr = progLen + 2;
		for (int run = 0; run < numRuns; run++) begin
			traceQ.delete();
			apbWrite(busPkg::ADDR_CTRL, 32'h1, 1'b0);
			if (run == 0) begin
				apbWrite(busPkg::IMEM_BASE + 12'h00C, 32'h00FF_FFFF, 1'b1); // Dropped
				apbWrite(busPkg::ADDR_CTRL, 32'h1, 1'b1);                   // Ignored
			end
			waitHalted(st);

			numEntries = int'(stim[ptr]);
			ptr++;
			if (traceQ.size() != numEntries)
				failRun($sformatf("run %0d wrote back %0d results, %0d expected",
				                  run, traceQ.size(), numEntries));
			for (int k = 0; k < numEntries; k++) begin
				entry = stim[ptr + k]; // rd, value, n/z/p/c
				checkWord($sformatf("trace[%0d].rd", k),
				          cpuPkg::dataWord_t'(traceQ[k].rd), cpuPkg::dataWord_t'(entry[23:20]));
				checkWord($sformatf("trace[%0d].value", k), traceQ[k].value, entry[19:4]);
				checkCcodes($sformatf("trace[%0d].ccodes", k), traceQ[k].ccodes, entry[3:0]);
			end
			ptr += numEntries;

			expSt.busy    = stim[ptr][0];
			expSt.halted  = stim[ptr][1];
			expSt.retired = stim[ptr][15:8];
			ptr++;
			checkStatus($sformatf("status after run %0d", run), st, expSt);
		end

		// Unmapped accesses
		apbReadCheck(12'h200, 32'h0, 1'b1);
		apbWrite(12'h080, 32'hDEAD_BEEF, 1'b1);
		apbReadCheck(12'h108, 32'h0, 1'b1);
		checkProgram(); // Unchanged by the rejected writes

		if (errCount == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			failRun("checks failed");
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module tb_miniCpu \
	--Mdir obj_dir -o Vtb_miniCpu || exit 1
./obj_dir/Vtb_miniCpu > sim.log 2>&1
cat sim.log
grep -qx "Everything OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	// Operands
	input  wire cpuPkg::dataWord_t i_srcA,
	input  wire cpuPkg::dataWord_t i_srcB,

	// Opcode
	input  wire cpuPkg::aluOp_e    i_opCode,
	input  wire                    i_opSel,

	// Results
	output cpuPkg::dataWord_t      o_result,
	output cpuPkg::ccodes_t        o_ccodes
);

	////////////////////////////////////////////////////////////////////////////
	// Internal signals
	////////////////////////////////////////////////////////////////////////////

	cpuPkg::dataWord_t setResult;               // LBI path
	cpuPkg::dataWord_t adderA, adderB, adderS;
	logic              adderI, adderO;
	cpuPkg::dataWord_t select0XX, select1XX;
	cpuPkg::dataWord_t finResult;

	// Set path, shift low byte of A above the immediate when opSel
	assign setResult = i_opSel ? {i_srcA[7:0], i_srcB[7:0]} : i_srcB;

	// Adder
	assign adderA = i_srcA ^ {cpuPkg::DATA_W{i_opCode[0]}}; // Invert A on SUB
	assign adderB = i_srcB;
	assign adderI = i_opCode[0];                            // Plus one on SUB
	assign {adderO, adderS} = {1'b0, adderA} + {1'b0, adderB} + {{cpuPkg::DATA_W{1'b0}}, adderI};

	// First level select on the low opcode bits
	always_comb begin
		case (i_opCode[1:0])
			2'b00:   select0XX = adderS;    // ADD
			2'b01:   select0XX = adderS;    // SUB
			2'b10:   select0XX = setResult; // LBI
			default: select0XX = i_srcB;    // MOVE
		endcase
	end

	always_comb begin
		case (i_opCode[1:0])
			2'b00:   select1XX = i_srcA & i_srcB;
			2'b01:   select1XX = i_srcA | i_srcB;
			2'b10:   select1XX = i_srcA ^ i_srcB;
			default: select1XX = i_srcB;    // PASSB
		endcase
	end

	// Second level on the top opcode bit
	assign finResult = i_opCode[2] ? select1XX : select0XX;
	assign o_result  = finResult;

	////////////////////////////////////////////////////////////////////////////
	// Condition codes
	////////////////////////////////////////////////////////////////////////////

	assign o_ccodes.n = finResult[cpuPkg::DATA_W-1];
	assign o_ccodes.z = ~(|finResult);
	assign o_ccodes.p = ~finResult[cpuPkg::DATA_W-1]; // Zero counts as positive
	assign o_ccodes.c = adderO;                       // Meaningful on ADD/SUB only

endmodule

`default_nettype wire

// ==== src/apbSlave.sv ====
`timescale 1ns/1ps
`default_nettype none

module apbSlave (
	input  wire                   i_clk,
	input  wire                   i_reset,

	// Host bus
	input  wire busPkg::apbReq_t  i_apb,
	output busPkg::apbRsp_t       o_apb,

	// Instruction store ports
	input  wire cpuPkg::instr_t   i_imemRdData,
	output logic                  o_imemWrEn,
	output cpuPkg::pcAddr_t       o_imemAddr,
	output cpuPkg::instr_t        o_imemWrData,
	output cpuPkg::pcAddr_t       o_imemRdAddr,

	// Controller side
	input  wire cpuPkg::status_t  i_status,
	output logic                  o_start
);

	localparam int PAD_W = busPkg::APB_DATA_W - $bits(cpuPkg::instr_t);

	logic setupPh, accessPh;
	logic imemHit, ctrlHit, statHit, mapped;
	logic errNext, errQ;
	logic [busPkg::APB_DATA_W-1:0] rdMux, rdDataQ;

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////

	assign setupPh  = i_apb.psel && !i_apb.penable;
	assign accessPh = i_apb.psel && i_apb.penable;

	assign imemHit = i_apb.paddr[busPkg::APB_ADDR_W-1:7] == busPkg::IMEM_BASE[busPkg::APB_ADDR_W-1:7]
	              && i_apb.paddr[6:0] <= busPkg::IMEM_LAST[6:0];
	assign ctrlHit = i_apb.paddr == busPkg::ADDR_CTRL;
	assign statHit = i_apb.paddr == busPkg::ADDR_STATUS;
	assign mapped  = imemHit || ctrlHit || statHit;

	// Busy rule, program and start are locked during a run
	assign errNext = !mapped || (i_apb.pwrite && (imemHit || ctrlHit) && i_status.busy);

	// Readback data
	always_comb begin
		rdMux = '0;                        // Unmapped and CTRL read as zero
		if (imemHit)
			rdMux = {{PAD_W{1'b0}}, i_imemRdData};
		else if (statHit)
			rdMux = {16'b0, i_status.retired, 6'b0, i_status.halted, i_status.busy};
	end

	////////////////////////////////////////////////////////////////////////////
	// Response registers, captured in setup and shown in access
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset)
			errQ <= 1'b0;
		else
			errQ <= setupPh && errNext; // High for the access cycle only
	end

	always_ff @(posedge i_clk) begin
		if (setupPh)
			rdDataQ <= i_apb.pwrite ? '0 : rdMux;
	end

	assign o_apb.prdata  = rdDataQ;
	assign o_apb.pready  = 1'b1;
	assign o_apb.pslverr = accessPh && errQ;

	// Side effects land in access, dropped when flagged
	assign o_imemWrEn   = accessPh && i_apb.pwrite && imemHit && !errQ;
	assign o_imemAddr   = i_apb.paddr[6:2];              // Word index
	assign o_imemWrData = cpuPkg::instr_t'(i_apb.pwdata[$bits(cpuPkg::instr_t)-1:0]);
	assign o_imemRdAddr = i_apb.paddr[6:2];
	assign o_start      = accessPh && i_apb.pwrite && ctrlHit && !errQ
	                   && i_apb.pwdata[busPkg::CTRL_START_BIT];

endmodule

`default_nettype wire

// ==== src/busPkg.sv ====
`default_nettype none

package busPkg;

	////////////////////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////////////////////

	localparam int APB_ADDR_W = 12;
	localparam int APB_DATA_W = 32;

	localparam logic [APB_ADDR_W-1:0] IMEM_BASE   = 12'h000; // First program word
	localparam logic [APB_ADDR_W-1:0] IMEM_LAST   = 12'h07C; // Last program word
	localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 12'h100;
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 12'h104;

	localparam int CTRL_START_BIT = 0; // Write 1 here to launch a run

	////////////////////////////////////////////////////////////////////////////
	// APB channel structs
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [APB_DATA_W-1:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [APB_DATA_W-1:0] prdata;
		logic                  pready;  // Tied high, no wait states
		logic                  pslverr;
	} apbRsp_t;

endpackage

`default_nettype wire

// ==== src/cpuControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuControl (
	input  wire                      i_clk,
	input  wire                      i_reset,
	input  wire                      i_start,     // One-cycle pulse from the bus side

	// Fetch side
	input  wire cpuPkg::instr_t      i_instr,
	input  wire cpuPkg::pcAddr_t     i_pc,

	// Register file read data
	input  wire cpuPkg::dataWord_t   i_rdA,
	input  wire cpuPkg::dataWord_t   i_rdB,

	// ALU results
	input  wire cpuPkg::dataWord_t   i_aluResult,
	input  wire cpuPkg::ccodes_t     i_aluCcodes,

	// Program counter steering
	output logic                     o_pcClear,
	output logic                     o_pcInc,
	output logic                     o_pcLoad,
	output cpuPkg::pcAddr_t          o_pcTarget,

	// Register file steering
	output cpuPkg::regIdx_t          o_regRdA,
	output cpuPkg::regIdx_t          o_regRdB,
	output logic                     o_regWrEn,
	output cpuPkg::regIdx_t          o_regWrAddr,
	output cpuPkg::dataWord_t        o_regWrData,

	// ALU steering
	output cpuPkg::dataWord_t        o_aluA,
	output cpuPkg::dataWord_t        o_aluB,
	output cpuPkg::aluOp_e           o_aluOp,
	output logic                     o_aluOpSel,

	output cpuPkg::status_t          o_status,
	output cpuPkg::wbTrace_t         o_trace
);

	cpuPkg::ctrlState_e state;
	cpuPkg::instr_t     instrQ;   // Latched in FETCH
	cpuPkg::ccodes_t    flagsQ;
	logic [7:0]         retiredQ;

	logic inExec, isAluOp, isBranch, brTaken;

	assign inExec   = state == cpuPkg::ST_EXEC;
	assign isAluOp  = inExec && (instrQ.kind == cpuPkg::KIND_REG ||
	                             instrQ.kind == cpuPkg::KIND_IMM);
	assign isBranch = inExec && instrQ.kind == cpuPkg::KIND_BRANCH;
	assign brTaken  = |(instrQ.rd & {flagsQ.n, flagsQ.z, flagsQ.p}); // rd is the n/z/p mask

	////////////////////////////////////////////////////////////////////////////
	// FSM and state registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state <= cpuPkg::ST_IDLE;
		end else begin
			case (state)
				cpuPkg::ST_IDLE,
				cpuPkg::ST_DONE: if (i_start) state <= cpuPkg::ST_FETCH;
				cpuPkg::ST_FETCH: state <= cpuPkg::ST_EXEC;
				cpuPkg::ST_EXEC: begin
					if (instrQ.kind == cpuPkg::KIND_HALT)
						state <= cpuPkg::ST_DONE; // Stop here and leave the PC
					else
						state <= cpuPkg::ST_FETCH;
				end
				default: state <= cpuPkg::ST_IDLE;
			endcase
		end
	end

	// Instruction register
	always_ff @(posedge i_clk) begin
		if (state == cpuPkg::ST_FETCH)
			instrQ <= i_instr;
	end

	// Flags and retired count
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			flagsQ   <= '0;
			retiredQ <= '0;
		end else begin
			if (isAluOp)
				flagsQ <= i_aluCcodes;
			if (i_start)
				retiredQ <= '0;                // Counts only the current run
			else if (isAluOp || isBranch)
				retiredQ <= retiredQ + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Datapath steering
	////////////////////////////////////////////////////////////////////////////

	assign o_pcClear = i_start;
	assign o_pcInc   = isAluOp;
	assign o_pcLoad  = isBranch;  // Branches always resolve through load
	assign o_pcTarget = brTaken ? instrQ.imm8[$bits(cpuPkg::pcAddr_t)-1:0]
	                            : cpuPkg::pcAddr_t'(i_pc + 1'b1); // Fall through

	assign o_regRdA    = instrQ.ra;
	assign o_regRdB    = instrQ.rb;
	assign o_regWrEn   = isAluOp;
	assign o_regWrAddr = instrQ.rd;
	assign o_regWrData = i_aluResult;

	// srcB from register or immediate
	assign o_aluA     = i_rdA;
	assign o_aluB     = (instrQ.kind == cpuPkg::KIND_IMM) ? cpuPkg::dataWord_t'(instrQ.imm8)
	                                                       : i_rdB;
	assign o_aluOp    = instrQ.aluOp;
	assign o_aluOpSel = instrQ.opSel;

	always_comb begin
		o_status.busy    = state == cpuPkg::ST_FETCH || inExec;
		o_status.halted  = state == cpuPkg::ST_DONE;
		o_status.retired = retiredQ;
	end

	// One trace entry per register write
	always_comb begin
		o_trace.valid  = isAluOp;
		o_trace.rd     = instrQ.rd;
		o_trace.value  = i_aluResult;
		o_trace.ccodes = i_aluCcodes;
	end

endmodule

`default_nettype wire

// ==== src/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	// Datapath sizing
	localparam int DATA_W     = 16;
	localparam int NUM_REGS   = 8;
	localparam int IMEM_DEPTH = 32;

	typedef logic [DATA_W-1:0]             dataWord_t;
	typedef logic [$clog2(NUM_REGS)-1:0]   regIdx_t;
	typedef logic [$clog2(IMEM_DEPTH)-1:0] pcAddr_t;

	// ALU ops, 0XX arithmetic/set and 1XX logic
	typedef enum logic [2:0] {
		OP_ADD   = 3'b000,
		OP_SUB   = 3'b001, // B minus A
		OP_LBI   = 3'b010,
		OP_MOVE  = 3'b011, // Register copy of srcB
		OP_AND   = 3'b100,
		OP_OR    = 3'b101,
		OP_XOR   = 3'b110,
		OP_PASSB = 3'b111  // Immediate copy of srcB
	} aluOp_e;

	typedef enum logic [1:0] {
		KIND_REG    = 2'b00, // srcB from rb
		KIND_IMM    = 2'b01, // srcB is zero-extended imm8
		KIND_BRANCH = 2'b10,
		KIND_HALT   = 2'b11
	} instrKind_e;

	typedef struct packed {
		instrKind_e kind;
		aluOp_e     aluOp;
		logic       opSel;
		regIdx_t    rd;    // n/z/p mask on BRANCH
		regIdx_t    ra;
		regIdx_t    rb;
		logic [7:0] imm8;  // Low bits hold the BRANCH target
		logic       spare;
	} instr_t;

	typedef struct packed {
		logic n;
		logic z;
		logic p;
		logic c;
	} ccodes_t;

	typedef struct packed {
		logic      valid;
		regIdx_t   rd;
		dataWord_t value;
		ccodes_t   ccodes;
	} wbTrace_t;

	typedef struct packed {
		logic       busy;
		logic       halted;
		logic [7:0] retired;
	} status_t;

	// Controller states
	typedef enum logic [1:0] {
		ST_IDLE  = 2'b00,
		ST_FETCH = 2'b01,
		ST_EXEC  = 2'b10,
		ST_DONE  = 2'b11
	} ctrlState_e;

endpackage

`default_nettype wire

// ==== src/miniCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module miniCpu (
	input  wire                   i_clk,
	input  wire                   i_reset,
	input  wire busPkg::apbReq_t  i_apb,
	output busPkg::apbRsp_t       o_apb,
	output cpuPkg::wbTrace_t      o_trace
);

	////////////////////////////////////////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////////////////////////////////////////

	// Instruction store
	logic              imemWrEn;
	cpuPkg::pcAddr_t   imemWrAddr, imemRdAddrB, pc;
	cpuPkg::instr_t    imemWrData, imemRdDataA, imemRdDataB;

	// Control
	logic              start, pcClear, pcInc, pcLoad;
	cpuPkg::pcAddr_t   pcTarget;
	cpuPkg::status_t   status;

	// Register file
	logic              regWrEn;
	cpuPkg::regIdx_t   regRdA, regRdB, regWrAddr;
	cpuPkg::dataWord_t regWrData, regDataA, regDataB;

	// ALU
	cpuPkg::dataWord_t aluA, aluB, aluResult;
	cpuPkg::aluOp_e    aluOp;
	logic              aluOpSel;
	cpuPkg::ccodes_t   aluCcodes;

	////////////////////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////////////////////

	apbSlave uBus (
		.i_clk(i_clk), .i_reset(i_reset), .i_apb(i_apb), .o_apb(o_apb),
		.i_imemRdData(imemRdDataB), .o_imemWrEn(imemWrEn), .o_imemAddr(imemWrAddr),
		.o_imemWrData(imemWrData), .o_imemRdAddr(imemRdAddrB),
		.i_status(status), .o_start(start)
	);

	// Port A feeds fetch, port B feeds bus readback
	wordStore #(.T_ENTRY(cpuPkg::instr_t), .DEPTH(cpuPkg::IMEM_DEPTH)) uImem (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_wrEn(imemWrEn), .i_wrAddr(imemWrAddr), .i_wrData(imemWrData),
		.i_rdAddrA(pc), .i_rdAddrB(imemRdAddrB),
		.o_rdDataA(imemRdDataA), .o_rdDataB(imemRdDataB)
	);

	wordStore #(.T_ENTRY(cpuPkg::dataWord_t), .DEPTH(cpuPkg::NUM_REGS)) uRegs (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_wrEn(regWrEn), .i_wrAddr(regWrAddr), .i_wrData(regWrData),
		.i_rdAddrA(regRdA), .i_rdAddrB(regRdB),
		.o_rdDataA(regDataA), .o_rdDataB(regDataB)
	);

	progCounter uPc (
		.i_clk(i_clk), .i_reset(i_reset), .i_clear(pcClear), .i_inc(pcInc),
		.i_load(pcLoad), .i_target(pcTarget), .o_pc(pc)
	);

	cpuControl uCtrl (
		.i_clk(i_clk), .i_reset(i_reset), .i_start(start),
		.i_instr(imemRdDataA), .i_pc(pc), .i_rdA(regDataA), .i_rdB(regDataB),
		.i_aluResult(aluResult), .i_aluCcodes(aluCcodes),
		.o_pcClear(pcClear), .o_pcInc(pcInc), .o_pcLoad(pcLoad), .o_pcTarget(pcTarget),
		.o_regRdA(regRdA), .o_regRdB(regRdB), .o_regWrEn(regWrEn),
		.o_regWrAddr(regWrAddr), .o_regWrData(regWrData),
		.o_aluA(aluA), .o_aluB(aluB), .o_aluOp(aluOp), .o_aluOpSel(aluOpSel),
		.o_status(status), .o_trace(o_trace)
	);

	alu uAlu (
		.i_srcA(aluA), .i_srcB(aluB), .i_opCode(aluOp), .i_opSel(aluOpSel),
		.o_result(aluResult), .o_ccodes(aluCcodes)
	);

endmodule

`default_nettype wire

// ==== src/progCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Fetch address register
module progCounter (
	input  wire                    i_clk,
	input  wire                    i_reset,
	input  wire                    i_clear,  // Back to word 0 on start
	input  wire                    i_inc,
	input  wire                    i_load,   // Branch resolution
	input  wire cpuPkg::pcAddr_t   i_target,
	output cpuPkg::pcAddr_t        o_pc
);

	cpuPkg::pcAddr_t pcQ;

	// Clear wins over load, load wins over increment
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			pcQ <= '0;
		end else if (i_clear) begin
			pcQ <= '0;
		end else if (i_load) begin
			pcQ <= i_target;
		end else if (i_inc) begin
			pcQ <= pcQ + 1'b1; // Wraps past the last word
		end
	end

	assign o_pc = pcQ;

endmodule

`default_nettype wire

// ==== src/wordStore.sv ====
`timescale 1ns/1ps
`default_nettype none

// Small storage array, one write port and two async read ports
module wordStore #(
	parameter type T_ENTRY = logic [15:0],
	parameter int  DEPTH   = 8
) (
	input  wire                     i_clk,
	input  wire                     i_reset,

	// Write port
	input  wire                     i_wrEn,
	input  wire [$clog2(DEPTH)-1:0] i_wrAddr,
	input  wire T_ENTRY             i_wrData,

	// Read ports
	input  wire [$clog2(DEPTH)-1:0] i_rdAddrA,
	input  wire [$clog2(DEPTH)-1:0] i_rdAddrB,
	output T_ENTRY                  o_rdDataA,
	output T_ENTRY                  o_rdDataB
);

	T_ENTRY mem [DEPTH];

	////////////////////////////////////////////////////////////////////////////
	// Storage update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			mem <= '{default: '0}; // Whole array back to zero
		end else if (i_wrEn) begin
			mem[i_wrAddr] <= i_wrData;
		end
	end

	// Combinational reads, same-cycle writes not bypassed
	assign o_rdDataA = mem[i_rdAddrA];
	assign o_rdDataB = mem[i_rdAddrB];

endmodule

`default_nettype wire
